/* rtl/pfifo_config.svh */
// Build-time sizing shared by the datapath and the register block
// PFIFO_DEPTH must be a power of two and fit into PFIFO_LEVEL_WIDTH bits
// Register data is fixed at 16 bits, so a level must fit in one byte
`ifndef PFIFO_CONFIG_SVH
`define PFIFO_CONFIG_SVH

// Payload bits carried by one beat
`define PFIFO_DATA_WIDTH 32

// Entries in each of the two FIFOs
`define PFIFO_DEPTH 8

// Level counters must be able to hold the full depth
`define PFIFO_LEVEL_WIDTH 4

// Width of the starvation limit and of the arbiter skip counter
`define PFIFO_STARVE_WIDTH 4

// Register bus geometry
`define PFIFO_REG_ADDR_WIDTH 2
`define PFIFO_REG_DATA_WIDTH 16

`endif

/* rtl/pfifo_reg_pkg.sv */
// Register side types and the register map
// STATUS is read only, writes to it and to address 3 are ignored
`include "pfifo_config.svh"

package pfifo_reg_pkg;

    // Register map
    localparam logic [`PFIFO_REG_ADDR_WIDTH-1:0] ADDR_CTRL   = 2'd0;
    localparam logic [`PFIFO_REG_ADDR_WIDTH-1:0] ADDR_STARVE = 2'd1;
    localparam logic [`PFIFO_REG_ADDR_WIDTH-1:0] ADDR_STATUS = 2'd2;

    // A single register access, reads are decoded from addr alone
    typedef struct packed {
        logic                              write;
        logic [`PFIFO_REG_ADDR_WIDTH-1:0]  addr;
        logic [`PFIFO_REG_DATA_WIDTH-1:0]  wdata;
    } reg_req_t;

    // Control fields handed to the datapath
    typedef struct packed {
        logic                            enable;
        logic                            flush;
        // A limit of zero switches the starvation guard off
        logic [`PFIFO_STARVE_WIDTH-1:0]  starve_limit;
    } ctrl_t;

    // Fill levels reported back from the two FIFOs
    typedef struct packed {
        logic [`PFIFO_LEVEL_WIDTH-1:0] hp_level;
        logic [`PFIFO_LEVEL_WIDTH-1:0] lp_level;
    } status_t;

endpackage

/* rtl/pfifo_regs.sv */
// Control and status registers beside the datapath
// Reads are combinational on the address, writes land at the next edge
`timescale 1ns/1ps
`include "pfifo_config.svh"

module pfifo_regs (
    input  logic                              clock,
    input  logic                              rst_n,
    input  pfifo_reg_pkg::reg_req_t           reg_req,
    output logic [`PFIFO_REG_DATA_WIDTH-1:0]  reg_rdata,
    input  pfifo_reg_pkg::status_t            status,
    output pfifo_reg_pkg::ctrl_t              ctrl
);

    logic                           enable_q;
    logic                           flush_q;
    logic [`PFIFO_STARVE_WIDTH-1:0] limit_q;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            enable_q <= 1'b0;
            flush_q  <= 1'b0;
            limit_q  <= '0;
        end else begin
            // Flush is a single cycle strobe, it drops unless written again
            flush_q <= 1'b0;
            if (reg_req.write) begin
                case (reg_req.addr)
                    pfifo_reg_pkg::ADDR_CTRL: begin
                        enable_q <= reg_req.wdata[0];
                        flush_q  <= reg_req.wdata[1];
                    end
                    pfifo_reg_pkg::ADDR_STARVE: begin
                        limit_q <= reg_req.wdata[`PFIFO_STARVE_WIDTH-1:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign ctrl.enable       = enable_q;
    assign ctrl.flush        = flush_q;
    assign ctrl.starve_limit = limit_q;

    always_comb begin
        reg_rdata = '0;
        case (reg_req.addr)
            // The flush bit always reads back as zero
            pfifo_reg_pkg::ADDR_CTRL:   reg_rdata[0] = enable_q;
            pfifo_reg_pkg::ADDR_STARVE: reg_rdata[`PFIFO_STARVE_WIDTH-1:0] = limit_q;
            pfifo_reg_pkg::ADDR_STATUS: begin
                // lp level in the high byte, hp level in the low byte
                reg_rdata[8 +: `PFIFO_LEVEL_WIDTH] = status.lp_level;
                reg_rdata[0 +: `PFIFO_LEVEL_WIDTH] = status.hp_level;
            end
            default: reg_rdata = '0;
        endcase
    end

endmodule

/* rtl/prioritised_fifo.sv */
// Two-class prioritised stream FIFO, hp wins unless the lp guard fires
// Out_ready reaches the input ready signals combinationally through pop
`timescale 1ns/1ps
`include "pfifo_config.svh"

module prioritised_fifo (
    input  logic                              clock,
    input  logic                              rst_n,
    input  stream_pkg::beat_t                 in_hp_data,
    input  logic                              in_hp_valid,
    output logic                              in_hp_ready,
    input  stream_pkg::beat_t                 in_lp_data,
    input  logic                              in_lp_valid,
    output logic                              in_lp_ready,
    output stream_pkg::beat_t                 out_data,
    output logic                              out_valid,
    input  logic                              out_ready,
    input  pfifo_reg_pkg::reg_req_t           reg_req,
    output logic [`PFIFO_REG_DATA_WIDTH-1:0]  reg_rdata
);

    pfifo_reg_pkg::ctrl_t           ctrl;
    pfifo_reg_pkg::status_t         status;
    stream_pkg::beat_t              hp_head;
    stream_pkg::beat_t              lp_head;
    logic                           hp_valid;
    logic                           lp_valid;
    logic                           hp_pop;
    logic                           lp_pop;
    logic [`PFIFO_LEVEL_WIDTH-1:0]  hp_level;
    logic [`PFIFO_LEVEL_WIDTH-1:0]  lp_level;

    // Both FIFOs share the flush strobe from the register block
    stream_fifo u_hp_fifo (
        .clock      (clock),
        .rst_n      (rst_n),
        .flush      (ctrl.flush),
        .in_data    (in_hp_data),
        .in_valid   (in_hp_valid),
        .in_ready   (in_hp_ready),
        .head       (hp_head),
        .head_valid (hp_valid),
        .pop        (hp_pop),
        .level      (hp_level)
    );

    stream_fifo u_lp_fifo (
        .clock      (clock),
        .rst_n      (rst_n),
        .flush      (ctrl.flush),
        .in_data    (in_lp_data),
        .in_valid   (in_lp_valid),
        .in_ready   (in_lp_ready),
        .head       (lp_head),
        .head_valid (lp_valid),
        .pop        (lp_pop),
        .level      (lp_level)
    );

    priority_arbiter u_arbiter (
        .clock      (clock),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .hp_head    (hp_head),
        .hp_valid   (hp_valid),
        .hp_pop     (hp_pop),
        .lp_head    (lp_head),
        .lp_valid   (lp_valid),
        .lp_pop     (lp_pop),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    // Levels are reported live, without any register stage
    assign status.hp_level = hp_level;
    assign status.lp_level = lp_level;

    pfifo_regs u_regs (
        .clock      (clock),
        .rst_n      (rst_n),
        .reg_req    (reg_req),
        .reg_rdata  (reg_rdata),
        .status     (status),
        .ctrl       (ctrl)
    );

endmodule

/* rtl/priority_arbiter.sv */
// Combinational hp/lp selection with an optional lp starvation guard
// The chosen source is locked while the output is stalled
`timescale 1ns/1ps
`include "pfifo_config.svh"

module priority_arbiter (
    input  logic                    clock,
    input  logic                    rst_n,
    input  pfifo_reg_pkg::ctrl_t    ctrl,
    input  stream_pkg::beat_t       hp_head,
    input  logic                    hp_valid,
    output logic                    hp_pop,
    input  stream_pkg::beat_t       lp_head,
    input  logic                    lp_valid,
    output logic                    lp_pop,
    output stream_pkg::beat_t       out_data,
    output logic                    out_valid,
    input  logic                    out_ready
);

    // Number of hp beats sent while lp was waiting
    logic [`PFIFO_STARVE_WIDTH-1:0] skip_count;
    logic                           starved;
    logic                           fire;
    logic                           hold_q;
    stream_pkg::src_t               hold_src_q;
    stream_pkg::src_t               rule_sel;
    stream_pkg::src_t               sel;

    // Greater-or-equal covers a limit lowered below the current count
    assign starved = (ctrl.starve_limit != '0) && lp_valid &&
                     (skip_count >= ctrl.starve_limit);

    always_comb begin
        if (hp_valid && !starved) begin
            rule_sel = stream_pkg::SRC_HP;
        end else if (lp_valid) begin
            rule_sel = stream_pkg::SRC_LP;
        end else begin
            rule_sel = stream_pkg::SRC_HP;
        end
    end

    // A stalled beat keeps its source even if the other FIFO fills meanwhile
    assign sel = hold_q ? hold_src_q : rule_sel;

    assign out_data  = (sel == stream_pkg::SRC_HP) ? hp_head : lp_head;
    assign out_valid = ctrl.enable && ((sel == stream_pkg::SRC_HP) ? hp_valid : lp_valid);

    assign fire   = out_valid && out_ready;
    assign hp_pop = fire && (sel == stream_pkg::SRC_HP);
    assign lp_pop = fire && (sel == stream_pkg::SRC_LP);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            hold_q     <= 1'b0;
            hold_src_q <= stream_pkg::SRC_HP;
        end else begin
            hold_q     <= out_valid && !out_ready;
            hold_src_q <= sel;
        end
    end

    // Skip counter only moves on a transfer, so a stall keeps it frozen
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            skip_count <= '0;
        end else if (lp_pop) begin
            skip_count <= '0;
        end else if (hp_pop && lp_valid && (skip_count < ctrl.starve_limit)) begin
            skip_count <= skip_count + 1'b1;
        end
    end

endmodule

/* rtl/stream_fifo.sv */
// Synchronous FIFO with a fall-through head, depth must be a power of two
// Input ready depends on pop, so a full FIFO can take a beat while it drains
// Ready is low during a flush, so no accepted beat is thrown away
`timescale 1ns/1ps
`include "pfifo_config.svh"

module stream_fifo (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            flush,
    input  stream_pkg::beat_t               in_data,
    input  logic                            in_valid,
    output logic                            in_ready,
    output stream_pkg::beat_t               head,
    output logic                            head_valid,
    input  logic                            pop,
    output logic [`PFIFO_LEVEL_WIDTH-1:0]   level
);

    localparam int PTR_WIDTH = $clog2(`PFIFO_DEPTH);
    localparam logic [`PFIFO_LEVEL_WIDTH-1:0] FULL_LEVEL = `PFIFO_LEVEL_WIDTH'(`PFIFO_DEPTH);

    // Storage has no reset, the pointers and level decide what is valid
    stream_pkg::beat_t mem [`PFIFO_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic                 empty;
    logic                 full;
    logic                 do_write;
    logic                 do_read;

    assign empty = (level == '0);
    assign full  = (level == FULL_LEVEL);

    // A pop on an empty FIFO is ignored
    assign do_read = pop && !empty;

    // When full, the slot freed by a read this cycle can be refilled at once
    assign in_ready = (!full || do_read) && !flush;
    assign do_write = in_valid && in_ready;

    // The head is read straight from the array, so it is visible one edge after the write
    assign head       = mem[rd_ptr];
    assign head_valid = !empty;

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            // Pointers wrap naturally since the depth is a power of two
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous read and write leave the level unchanged
            case ({do_write, do_read})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

/* rtl/stream_pkg.sv */
// Datapath types shared by the FIFOs, the arbiter and the top level
// Only the payload travels in a beat, there are no framing sidebands
`include "pfifo_config.svh"

package stream_pkg;

    // One beat of the stream, kept as a struct so sidebands can be added later
    typedef struct packed {
        logic [`PFIFO_DATA_WIDTH-1:0] data;
    } beat_t;

    // Source of the beat that the arbiter currently presents
    typedef enum logic {
        SRC_HP = 1'b0,
        SRC_LP = 1'b1
    } src_t;

endpackage

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; a failing check exits nonzero
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module prioritised_fifo_tb \
    -f verilog.f \
    -o prioritised_fifo_sim

./obj_dir/prioritised_fifo_sim

/* verification/prioritised_fifo_tb.sv */
// Random testbench with a queue model of both classes and of the arbiter rule
// Outputs are sampled at the falling edge, inputs change 2 ns after the rising edge
`timescale 1ns/1ps
`include "pfifo_config.svh"

module prioritised_fifo_tb;

    localparam int DW = `PFIFO_DATA_WIDTH;
    localparam int DEPTH = `PFIFO_DEPTH;
    localparam int MAX_CYCLES = 4000;

    logic clock;
    logic rst_n;
    stream_pkg::beat_t in_hp_data;
    logic in_hp_valid;
    logic in_hp_ready;
    stream_pkg::beat_t in_lp_data;
    logic in_lp_valid;
    logic in_lp_ready;
    stream_pkg::beat_t out_data;
    logic out_valid;
    logic out_ready;
    pfifo_reg_pkg::reg_req_t reg_req;
    logic [`PFIFO_REG_DATA_WIDTH-1:0] reg_rdata;

    // Stimulus for the next cycle and an optional register read check
    logic hp_v;
    logic lp_v;
    logic ordy;
    pfifo_reg_pkg::reg_req_t req;
    logic rd_check;
    logic [`PFIFO_REG_DATA_WIDTH-1:0] rd_expect;

    // Model state mirrors the queues, the control registers and the arbiter
    logic [DW-1:0] q_hp[$];
    logic [DW-1:0] q_lp[$];
    logic m_enable;
    logic m_flush;
    logic [`PFIFO_STARVE_WIDTH-1:0] m_limit;
    logic [`PFIFO_STARVE_WIDTH-1:0] m_skip;
    logic m_hold;
    logic m_hold_src;
    integer seed;
    int cycles;

    prioritised_fifo uut (
        .clock       (clock),
        .rst_n       (rst_n),
        .in_hp_data  (in_hp_data),
        .in_hp_valid (in_hp_valid),
        .in_hp_ready (in_hp_ready),
        .in_lp_data  (in_lp_data),
        .in_lp_valid (in_lp_valid),
        .in_lp_ready (in_lp_ready),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .reg_req     (reg_req),
        .reg_rdata   (reg_rdata)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Ends a run that never reaches its final message
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [DW-1:0] actual,
                               input logic [DW-1:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic reset_model();
        q_hp.delete();
        q_lp.delete();
        m_enable = 1'b0;
        m_flush = 1'b0;
        m_limit = '0;
        m_skip = '0;
        m_hold = 1'b0;
        m_hold_src = 1'b0;
    endtask

    // One clock cycle: drive, check at the falling edge, then advance the model
    task automatic run_cycle();
        logic [31:0] r;
        logic lp_waiting;
        logic starved;
        logic sel;
        logic sel_ne;
        logic exp_valid;
        logic hp_pop;
        logic lp_pop;
        logic hp_rdy;
        logic lp_rdy;
        @(posedge clock);
        #2;
        r = $random(seed);
        in_hp_data.data = r;
        r = $random(seed);
        in_lp_data.data = r;
        in_hp_valid = hp_v;
        in_lp_valid = lp_v;
        out_ready = ordy;
        reg_req = req;
        @(negedge clock);
        // Lp occupancy seen by the arbiter during this cycle, before any update
        lp_waiting = (q_lp.size() > 0);
        // Selection rule, 1 means lp, with the stalled source locked
        starved = (m_limit != 0) && lp_waiting && (m_skip >= m_limit);
        if (m_hold)
            sel = m_hold_src;
        else
            sel = (q_hp.size() > 0 && !starved) ? 1'b0 : lp_waiting;
        sel_ne = sel ? lp_waiting : (q_hp.size() > 0);
        exp_valid = m_enable && sel_ne;
        check_value("out_valid", DW'(out_valid), DW'(exp_valid));
        if (exp_valid)
            check_value("out_data", out_data.data, sel ? q_lp[0] : q_hp[0]);
        hp_pop = exp_valid && ordy && !sel;
        lp_pop = exp_valid && ordy && sel;
        hp_rdy = (q_hp.size() < DEPTH || hp_pop) && !m_flush;
        lp_rdy = (q_lp.size() < DEPTH || lp_pop) && !m_flush;
        check_value("in_hp_ready", DW'(in_hp_ready), DW'(hp_rdy));
        check_value("in_lp_ready", DW'(in_lp_ready), DW'(lp_rdy));
        if (rd_check)
            check_value("reg_rdata", DW'(reg_rdata), DW'(rd_expect));
        // State after the coming rising edge
        if (m_flush) begin
            q_hp.delete();
            q_lp.delete();
        end else begin
            if (hp_pop)
                void'(q_hp.pop_front());
            if (lp_pop)
                void'(q_lp.pop_front());
            if (hp_v && hp_rdy)
                q_hp.push_back(in_hp_data.data);
            if (lp_v && lp_rdy)
                q_lp.push_back(in_lp_data.data);
        end
        if (lp_pop)
            m_skip = '0;
        else if (hp_pop && lp_waiting && m_skip < m_limit)
            m_skip = m_skip + 1'b1;
        m_hold = exp_valid && !ordy;
        m_hold_src = sel;
        m_flush = 1'b0;
        if (req.write && req.addr == pfifo_reg_pkg::ADDR_CTRL) begin
            m_enable = req.wdata[0];
            m_flush = req.wdata[1];
        end
        if (req.write && req.addr == pfifo_reg_pkg::ADDR_STARVE)
            m_limit = req.wdata[`PFIFO_STARVE_WIDTH-1:0];
    endtask

    task automatic reg_write(input logic [1:0] addr, input logic [15:0] data);
        req = '{write: 1'b1, addr: addr, wdata: data};
        run_cycle();
        req = '0;
    endtask

    task automatic reg_read(input logic [1:0] addr, input logic [15:0] expected);
        req = '{write: 1'b0, addr: addr, wdata: 16'h0};
        rd_check = 1'b1;
        rd_expect = expected;
        run_cycle();
        rd_check = 1'b0;
        req = '0;
    endtask

    task automatic traffic(input int n, input logic hv, input logic lv, input logic rdy);
        hp_v = hv;
        lp_v = lv;
        ordy = rdy;
        repeat (n) run_cycle();
    endtask

    task automatic random_traffic(input int n);
        logic [31:0] r;
        repeat (n) begin
            r = $random(seed);
            hp_v = r[0];
            lp_v = r[1];
            ordy = r[2] | r[3];
            run_cycle();
        end
    endtask

    task automatic apply_reset();
        @(posedge clock);
        #2;
        rst_n = 1'b0;
        in_hp_valid = 1'b0;
        in_lp_valid = 1'b0;
        reg_req = '0;
        repeat (2) @(posedge clock);
        #2;
        rst_n = 1'b1;
        reset_model();
    endtask

    initial begin
        seed = 32'h478ab89e;
        cycles = 0;
        rst_n = 1'b0;
        in_hp_data = '0;
        in_lp_data = '0;
        in_hp_valid = 1'b0;
        in_lp_valid = 1'b0;
        out_ready = 1'b0;
        reg_req = '0;
        req = '0;
        rd_check = 1'b0;
        rd_expect = '0;
        hp_v = 1'b0;
        lp_v = 1'b0;
        ordy = 1'b0;
        reset_model();
        repeat (2) @(posedge clock);
        #2;
        rst_n = 1'b1;
        // Order within each class under random traffic, guard off
        reg_write(pfifo_reg_pkg::ADDR_CTRL, 16'h1);
        random_traffic(1200);
        // Strict priority: load both FIFOs while disabled, then drain
        reg_write(pfifo_reg_pkg::ADDR_CTRL, 16'h0);
        traffic(12, 1'b1, 1'b1, 1'b0);
        reg_write(pfifo_reg_pkg::ADDR_CTRL, 16'h1);
        traffic(24, 1'b0, 1'b0, 1'b1);
        // Starvation guard with both classes kept busy
        reg_write(pfifo_reg_pkg::ADDR_STARVE, 16'h3);
        traffic(400, 1'b1, 1'b1, 1'b1);
        // Back-pressure: flush, then twice the depth of writes with the output stalled
        reg_write(pfifo_reg_pkg::ADDR_STARVE, 16'h0);
        reg_write(pfifo_reg_pkg::ADDR_CTRL, 16'h3);
        traffic(2 * DEPTH, 1'b1, 1'b1, 1'b0);
        reg_read(pfifo_reg_pkg::ADDR_STATUS, 16'((DEPTH << 8) | DEPTH));
        traffic(3 * DEPTH, 1'b0, 1'b0, 1'b1);
        // Enable and flush
        reg_write(pfifo_reg_pkg::ADDR_CTRL, 16'h0);
        traffic(6, 1'b1, 1'b1, 1'b1);
        reg_write(pfifo_reg_pkg::ADDR_CTRL, 16'h2);
        traffic(1, 1'b0, 1'b0, 1'b1);
        reg_read(pfifo_reg_pkg::ADDR_STATUS, 16'h0);
        reg_write(pfifo_reg_pkg::ADDR_CTRL, 16'h1);
        traffic(6, 1'b0, 1'b0, 1'b1);
        // Mid-run reset with traffic and a nonzero limit
        reg_write(pfifo_reg_pkg::ADDR_STARVE, 16'h5);
        random_traffic(20);
        apply_reset();
        hp_v = 1'b0;
        lp_v = 1'b0;
        ordy = 1'b1;
        reg_read(pfifo_reg_pkg::ADDR_STARVE, 16'h0);
        // Both FIFOs must come out of reset empty
        reg_read(pfifo_reg_pkg::ADDR_STATUS, 16'h0);
        // Reset cleared enable, so set it again to let traffic reach the output
        reg_write(pfifo_reg_pkg::ADDR_CTRL, 16'h1);
        random_traffic(300);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+rtl
rtl/stream_pkg.sv
rtl/pfifo_reg_pkg.sv
rtl/stream_fifo.sv
rtl/priority_arbiter.sv
rtl/pfifo_regs.sv
rtl/prioritised_fifo.sv
verification/prioritised_fifo_tb.sv
